// ==== stream_merge_top.f ====
merge_pkg.sv
fifo_single_clock_reg_v2.sv
rr_merge.sv
stream_merge_top.sv
clk_gen_tb.sv
stream_merge_properties.sv
stream_merge_tb.sv

// ==== Bender.yml ====
package:
  name: stream_merge

sources:
  # design
  - merge_pkg.sv
  - fifo_single_clock_reg_v2.sv
  - rr_merge.sv
  - stream_merge_top.sv

  # testbench
  - target: test
    files:
      - clk_gen_tb.sv
      - stream_merge_properties.sv
      - stream_merge_tb.sv

// ==== stream_merge_tb.sv ====
// testbench for the two-lane merger, directed and LFSR traffic checked against a queue model

`timescale 1ns/100ps

module stream_merge_tb import merge_pkg::*; ();

  // --------------------------------------------------------------------------
  // run length
  // --------------------------------------------------------------------------
  localparam int  fifo_depth      = 8;
  localparam int  cnt_w           = $clog2(fifo_depth + 1);
  localparam real clk_period      = 100.0;
  localparam int  n_fair          = 8;
  localparam int  n_burst         = 30;
  localparam int  n_mix           = 100;
  localparam int  n_soak          = 300;
  localparam int  drain_max       = 4 * fifo_depth + 8;
  // phases plus one drain allowance each, directed writes included
  localparam int  stim_cycles     = n_fair + 12 + n_burst + n_mix + n_soak + 6 * drain_max + 10;
  localparam int  watchdog_cycles = 2 * stim_cycles + 50;

  logic             clk200;
  logic             nrst;
  logic             a_wr;
  logic             b_wr;
  sample_t          a_data;
  marker_t          b_data;
  logic             a_full;
  logic             a_empty;
  logic [cnt_w-1:0] a_cnt;
  logic             b_full;
  logic             b_empty;
  logic [cnt_w-1:0] b_cnt;
  logic             out_valid;
  merged_t          out_word;

  clk_gen_tb #(.period_ns(clk_period), .reset_cycles(4)) i_clk_gen (
    .clk200 (clk200),
    .nrst   (nrst)
  );

  stream_merge_top #(.fifo_depth(fifo_depth)) i_stream_merge_top (
    .clk200    (clk200),
    .nrst      (nrst),
    .a_wr      (a_wr),
    .a_data    (a_data),
    .b_wr      (b_wr),
    .b_data    (b_data),
    .a_full    (a_full),
    .a_empty   (a_empty),
    .a_cnt     (a_cnt),
    .b_full    (b_full),
    .b_empty   (b_empty),
    .b_cnt     (b_cnt),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  // --------------------------------------------------------------------------
  // failure reporting and the compare task
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // random source
  // --------------------------------------------------------------------------
  logic [31:0] lfsr_state = 32'hde3d;

  // fibonacci form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------

  // tag bit on top, marker zero-extended to 20 bits
  function automatic merged_t reference_word(input logic from_b, input sample_t s,
                                             input marker_t m);
    merged_t w;
    if (from_b) begin
      w = {1'b1, 4'h0, m};
    end else begin
      w = {1'b0, s};
    end
    return w;
  endfunction

  sample_t     qa[$];
  marker_t     qb[$];
  lane_e       rr_next;
  logic        model_ready = 1'b0;
  logic        exp_valid;
  merged_t     exp_word;
  int unsigned words_checked = 0;

  always @(posedge clk200) begin : model_compare
    logic pop_a;
    logic pop_b;
    logic take_a;
    logic take_b;
    if (!nrst) begin
      qa.delete();
      qb.delete();
      rr_next     = lane_a;
      exp_valid   = 1'b0;
      model_ready = 1'b1;
    end else if (model_ready) begin
      // DUT outputs still show the state after the previous edge
      check_value("out_valid", out_valid, exp_valid);
      if (exp_valid) begin
        check_value("out_word", out_word, exp_word);
        words_checked++;
      end
      check_value("a_cnt", a_cnt, qa.size());
      check_value("a_empty", a_empty, qa.size() == 0);
      check_value("a_full", a_full, qa.size() == fifo_depth);
      check_value("b_cnt", b_cnt, qb.size());
      check_value("b_empty", b_empty, qb.size() == 0);
      check_value("b_full", b_full, qb.size() == fifo_depth);
      // merger choice, from occupancy before this edge
      pop_a  = (qa.size() != 0) && ((qb.size() == 0) || (rr_next == lane_a));
      pop_b  = (qb.size() != 0) && ((qa.size() == 0) || (rr_next == lane_b));
      // full lane only takes a write together with a pop
      take_a = a_wr && ((qa.size() < fifo_depth) || pop_a);
      take_b = b_wr && ((qb.size() < fifo_depth) || pop_b);
      if ((qa.size() != 0) && (qb.size() != 0)) begin
        rr_next = pop_a ? lane_b : lane_a;
      end
      exp_valid = pop_a || pop_b;
      if (pop_a) begin
        exp_word = reference_word(1'b0, qa.pop_front(), '0);
      end else if (pop_b) begin
        exp_word = reference_word(1'b1, '0, qb.pop_front());
      end
      if (take_a) begin
        qa.push_back(a_data);
      end
      if (take_b) begin
        qb.push_back(b_data);
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus tasks, called on falling edges
  // --------------------------------------------------------------------------
  task automatic drive_lanes(input logic wa, input logic wb);
    logic [31:0] v;
    a_wr = wa;
    b_wr = wb;
    take_bits(20, v);
    a_data = v[19:0];
    take_bits(16, v);
    b_data = v[15:0];
  endtask

  // both lanes backlogged, sources must alternate from lane_a
  task automatic check_fairness();
    lane_e want;
    int    seen;
    want = lane_a;
    seen = 0;
    for (int i = 0; i < n_fair + 12; i++) begin
      @(negedge clk200);
      if (out_valid && (seen < n_fair)) begin
        check_value("out_word.src", out_word.src, want);
        want = (want == lane_a) ? lane_b : lane_a;
        seen++;
      end
      drive_lanes(i < n_fair, i < n_fair);
    end
    check_value("alternating words seen", seen, n_fair);
  endtask

  // one word into an idle merger, two cycles to the output
  task automatic single_write(input logic to_b);
    merged_t want;
    int      waited;
    @(negedge clk200);
    drive_lanes(!to_b, to_b);
    want = reference_word(to_b, a_data, b_data);
    @(negedge clk200);
    drive_lanes(1'b0, 1'b0);
    waited = 1;
    while (!out_valid && (waited < drain_max)) begin
      @(negedge clk200);
      waited++;
    end
    if (!out_valid) begin
      $display("single write on lane %s never reached the output", to_b ? "b" : "a");
      abort_run();
    end
    check_value("write to output latency", waited, 2);
    check_value("out_word", out_word, want);
  endtask

  // lane A written every cycle, lane B kept busy so A fills and overflows
  task automatic fill_lanes();
    logic saw_full;
    saw_full = 1'b0;
    for (int i = 0; i < n_burst; i++) begin
      @(negedge clk200);
      saw_full = saw_full || a_full;
      drive_lanes(1'b1, 1'b1);
    end
    check_value("a_full reached", saw_full, 1'b1);
  endtask

  // write rate per lane is 1 - 2**-rate_bits
  task automatic random_traffic(input int cycles, input int rate_bits);
    logic [31:0] ra;
    logic [31:0] rb;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk200);
      take_bits(rate_bits, ra);
      take_bits(rate_bits, rb);
      drive_lanes(ra != 0, rb != 0);
    end
  endtask

  task automatic wait_drained();
    int waited;
    @(negedge clk200);
    drive_lanes(1'b0, 1'b0);
    waited = 0;
    while (!(a_empty && b_empty && !out_valid) && (waited < drain_max)) begin
      @(negedge clk200);
      waited++;
    end
    if (!(a_empty && b_empty && !out_valid)) begin
      $display("lanes still busy %0d cycles after the traffic stopped", drain_max);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // test sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin : stimulus
    a_wr   = 1'b0;
    b_wr   = 1'b0;
    a_data = '0;
    b_data = '0;
    wait (nrst === 1'b1);
    @(negedge clk200);
    check_value("out_valid", out_valid, 1'b0);
    check_value("a_empty", a_empty, 1'b1);
    check_value("b_empty", b_empty, 1'b1);
    check_value("a_full", a_full, 1'b0);
    check_value("b_full", b_full, 1'b0);
    check_value("a_cnt", a_cnt, 0);
    check_value("b_cnt", b_cnt, 0);
    // pointer still at lane_a, so fairness goes first
    check_fairness();
    wait_drained();
    single_write(1'b0);
    single_write(1'b1);
    random_traffic(n_mix, 1);
    wait_drained();
    fill_lanes();
    wait_drained();
    random_traffic(n_soak, 2);
    wait_drained();
    @(negedge clk200);
    check_value("a_cnt", a_cnt, 0);
    check_value("b_cnt", b_cnt, 0);
    if ((words_checked > 0) && (i_stream_merge_top.i_props.assert_fails == 0)) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("%0d assertion failures, %0d output words checked",
               i_stream_merge_top.i_props.assert_fails, words_checked);
      abort_run();
    end
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    abort_run();
  end

endmodule

// ==== stream_merge_properties.sv ====
// concurrent checks on the merger top level, bound into every stream_merge_top instance

`timescale 1ns/100ps

module stream_merge_properties (
  input logic clk200,
  input logic nrst,
  input logic a_pop,
  input logic b_pop,
  input logic a_empty,
  input logic b_empty,
  input logic a_full,
  input logic b_full,
  input logic out_valid
);

  // failures so far, read by the testbench at the end
  int unsigned assert_fails = 0;

  // merger reads one lane per edge at most
  one_pop_per_edge: assert property (@(posedge clk200) disable iff (!nrst) !(a_pop && b_pop))
    else begin
      $error("a_pop and b_pop high in the same cycle");
      assert_fails++;
    end

  // output register cleared by reset
  idle_after_reset: assert property (@(posedge clk200) !nrst |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      assert_fails++;
    end

  // pops only on a lane with a head word
  pop_needs_data: assert property (@(posedge clk200) disable iff (!nrst)
    !(a_pop && a_empty) && !(b_pop && b_empty))
    else begin
      $error("pop on an empty lane");
      assert_fails++;
    end

  // flags come from one counter, never both
  flags_exclusive: assert property (@(posedge clk200) disable iff (!nrst)
    !(a_full && a_empty) && !(b_full && b_empty))
    else begin
      $error("full and empty high together");
      assert_fails++;
    end

endmodule

bind stream_merge_top stream_merge_properties i_props (
  .clk200    (clk200),
  .nrst      (nrst),
  .a_pop     (a_pop),
  .b_pop     (b_pop),
  .a_empty   (a_empty),
  .b_empty   (b_empty),
  .a_full    (a_full),
  .b_full    (b_full),
  .out_valid (out_valid)
);

// ==== clk_gen_tb.sv ====
// testbench clock and reset source, free-running clk200 with nrst held low for the first cycles

`timescale 1ns/100ps

module clk_gen_tb #(
  parameter real period_ns    = 100.0,
  parameter int  reset_cycles = 4
) (
  output logic clk200,
  output logic nrst
);

  // free-running clock, starts low
  initial begin
    clk200 = 1'b0;
    forever #(period_ns / 2.0) clk200 = ~clk200;
  end

  // reset over the first rising edges
  // released on a falling edge like the rest of the stimulus
  initial begin
    nrst = 1'b0;
    repeat (reset_cycles) @(posedge clk200);
    @(negedge clk200);
    nrst = 1'b1;
  end

endmodule

// ==== stream_merge_top.sv ====
// two-lane stream merger top, lane FIFOs side by side feeding the round-robin merger

`timescale 1ns/100ps

module stream_merge_top import merge_pkg::*; #(
  parameter int fifo_depth = 8
) (
  input  logic                              clk200,
  input  logic                              nrst,

  // lane A producer, sensor samples
  input  logic                              a_wr,
  input  sample_t                           a_data,

  // lane B producer, event markers
  input  logic                              b_wr,
  input  marker_t                           b_data,

  // lane status
  output logic                              a_full,
  output logic                              a_empty,
  output logic [$clog2(fifo_depth + 1)-1:0] a_cnt,
  output logic                              b_full,
  output logic                              b_empty,
  output logic [$clog2(fifo_depth + 1)-1:0] b_cnt,

  // merged stream
  output logic                              out_valid,
  output merged_t                           out_word
);

  // fall-through heads into the merger
  sample_t a_head;
  marker_t b_head;

  // merger read strobes
  logic a_pop;
  logic b_pop;

  // --------------------------------------------------------------------------
  // lane FIFOs
  // --------------------------------------------------------------------------

  fifo_single_clock_reg_v2 #(
    .depth     (fifo_depth),
    .payload_t (sample_t)
  ) i_fifo_a (
    .clk200 (clk200),
    .nrst   (nrst),
    .w_req  (a_wr),
    .w_data (a_data),
    .r_req  (a_pop),
    .r_data (a_head),
    .cnt    (a_cnt),
    .empty  (a_empty),
    .full   (a_full)
  );

  fifo_single_clock_reg_v2 #(
    .depth     (fifo_depth),
    .payload_t (marker_t)
  ) i_fifo_b (
    .clk200 (clk200),
    .nrst   (nrst),
    .w_req  (b_wr),
    .w_data (b_data),
    .r_req  (b_pop),
    .r_data (b_head),
    .cnt    (b_cnt),
    .empty  (b_empty),
    .full   (b_full)
  );

  // --------------------------------------------------------------------------
  // merger
  // --------------------------------------------------------------------------

  rr_merge i_merge (
    .clk200    (clk200),
    .nrst      (nrst),
    .a_head    (a_head),
    .a_empty   (a_empty),
    .b_head    (b_head),
    .b_empty   (b_empty),
    .a_pop     (a_pop),
    .b_pop     (b_pop),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

endmodule

// ==== rr_merge.sv ====
// round-robin reader of the two lane FIFOs, registers one tagged merged word per pop

`timescale 1ns/100ps

module rr_merge import merge_pkg::*; (
  input  logic    clk200,
  input  logic    nrst,

  // lane A FIFO head, fall-through
  input  sample_t a_head,
  input  logic    a_empty,

  // lane B FIFO head, fall-through
  input  marker_t b_head,
  input  logic    b_empty,

  // read strobes back to the FIFOs
  // never both high
  output logic    a_pop,
  output logic    b_pop,

  // merged stream, no back-pressure
  output logic    out_valid,
  output merged_t out_word
);

  // --------------------------------------------------------------------------
  // arbitration
  // --------------------------------------------------------------------------

  // lane that wins the next contested cycle
  lane_e rr_ptr;

  // both lanes have a word waiting
  logic contested;

  assign contested = !a_empty && !b_empty;

  // sole non-empty lane always wins
  // on contention the pointer decides
  assign a_pop = !a_empty && (b_empty || (rr_ptr == lane_a));
  assign b_pop = !b_empty && (a_empty || (rr_ptr == lane_b));

  // pointer only moves on contested cycles
  // it then points at the lane that lost
  always_ff @(posedge clk200) begin
    if (!nrst) begin
      rr_ptr <= lane_a;
    end else if (contested) begin
      if (a_pop) begin
        rr_ptr <= lane_b;
      end else begin
        rr_ptr <= lane_a;
      end
    end
  end

  // --------------------------------------------------------------------------
  // word formatting
  // --------------------------------------------------------------------------

  // sample fills the whole body
  function automatic merged_t tag_sample(input sample_t s);
    merged_t w;
    w.src  = lane_a;
    w.body = s;
    return w;
  endfunction

  // marker zero-extended into the low bits
  function automatic merged_t tag_marker(input marker_t m);
    merged_t w;
    w.src  = lane_b;
    w.body = {{(body_w - $bits(marker_t)){1'b0}}, m};
    return w;
  endfunction

  // --------------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------------

  // valid for the cycle after each pop
  always_ff @(posedge clk200) begin
    if (!nrst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= a_pop || b_pop;
    end
  end

  // payload, held when idle
  always_ff @(posedge clk200) begin
    if (a_pop) begin
      out_word <= tag_sample(a_head);
    end else if (b_pop) begin
      out_word <= tag_marker(b_head);
    end
  end

endmodule

// ==== fifo_single_clock_reg_v2.sv ====
// single-clock register FIFO in first-word-fall-through mode, payload type set per instance

`timescale 1ns/100ps

module fifo_single_clock_reg_v2 #(
  parameter int  depth     = 8,
  parameter type payload_t = logic [15:0]
) (
  input  logic                         clk200,
  input  logic                         nrst,

  // write side, plain strobe
  input  logic                         w_req,
  input  payload_t                     w_data,

  // read side, plain strobe
  // r_data always shows the head word
  input  logic                         r_req,
  output payload_t                     r_data,

  // status levels
  output logic [$clog2(depth + 1)-1:0] cnt,
  output logic                         empty,
  output logic                         full
);

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------

  // pointer needs at least one bit even for a single-entry FIFO
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  // counter spans 0 .. depth inclusive
  localparam int cnt_w = $clog2(depth + 1);

  // highest slot index, pointers wrap after it
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);

  // --------------------------------------------------------------------------
  // storage and control state
  // --------------------------------------------------------------------------

  // register array
  payload_t mem [depth];

  // next slot to write
  logic [ptr_w-1:0] wr_ptr;

  // slot holding the oldest word
  logic [ptr_w-1:0] rd_ptr;

  // requests that are actually taken this edge
  logic w_ok;
  logic r_ok;

  // advance a pointer, wrap at the last slot
  // depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] nxt;
    if (ptr == last_slot) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // --------------------------------------------------------------------------
  // request qualification
  // --------------------------------------------------------------------------

  // read while empty is ignored
  assign r_ok = r_req && !empty;

  // write while full only goes through together with a read
  // the freed head slot is the one wr_ptr points at
  assign w_ok = w_req && (!full || r_ok);

  // --------------------------------------------------------------------------
  // storage write
  // --------------------------------------------------------------------------

  always_ff @(posedge clk200) begin
    if (w_ok) begin
      mem[wr_ptr] <= w_data;
    end
  end

  // --------------------------------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------------------------------

  always_ff @(posedge clk200) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (w_ok) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (r_ok) begin
        rd_ptr <= ptr_next(rd_ptr);
      end

      // count moves only when exactly one side is taken
      case ({w_ok, r_ok})
        2'b10: begin
          cnt <= cnt + 1'b1;
        end
        2'b01: begin
          cnt <= cnt - 1'b1;
        end
        default: begin
          cnt <= cnt;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------

  // fall-through head, valid whenever not empty
  // stale slot content while empty, consumers look at empty first
  assign r_data = mem[rd_ptr];

  // flags straight from the counter
  // a write at edge N lowers empty right after edge N
  assign empty = (cnt == '0);
  assign full  = (cnt == cnt_w'(depth));

endmodule

// ==== merge_pkg.sv ====
// shared payload types for the two-lane stream merger, imported by the merger and the top level

package merge_pkg;

  // --------------------------------------------------------------------------
  // lane payloads
  // --------------------------------------------------------------------------

  // lane A, sensor sample
  // one 20-bit word, chan in the top nibble
  typedef struct packed {
    logic [3:0]  chan;
    logic [15:0] value;
  } sample_t;

  // lane B, event marker
  // one 16-bit word, code in the upper byte
  typedef struct packed {
    logic [7:0] code;
    logic [7:0] stamp;
  } marker_t;

  // --------------------------------------------------------------------------
  // merged output
  // --------------------------------------------------------------------------

  // body is as wide as the widest lane payload
  localparam int body_w = $bits(sample_t);

  // source tag of a merged word
  typedef enum logic {
    lane_a = 1'b0,
    lane_b = 1'b1
  } lane_e;

  // tagged output word, 21 bits
  // sample fills body as-is
  // marker sits zero-extended in the low 16 bits
  typedef struct packed {
    lane_e             src;
    logic [body_w-1:0] body;
  } merged_t;

endpackage
